//--- tb.f
design/vdp_pkg.sv
design/vdp_raster_timing.sv
design/vdp_register_decode.sv
design/vdp_vram_writer.sv
design/vdp_palette.sv
design/vdp_video_result.sv
design/vdp_top.sv
bench/vdp_checker.sv
bench/vdp_tb.sv

//--- Bender.yml
package:
  name: vdp

sources:
  - files:
      - design/vdp_pkg.sv
      - design/vdp_raster_timing.sv
      - design/vdp_register_decode.sv
      - design/vdp_vram_writer.sv
      - design/vdp_palette.sv
      - design/vdp_video_result.sv
      - design/vdp_top.sv
  - target: test
    files:
      - bench/vdp_checker.sv
      - bench/vdp_tb.sv

//--- bench/vdp_tb.sv
// Testbench for the video display processor
// Directed tests of raster read-back, VRAM writes, palette, blanking and sync timing

`timescale 1ns/1ns
`default_nettype none

module vdp_tb;

    localparam int FRAME_CYCLES = vdp_pkg::H_TOTAL * vdp_pkg::V_TOTAL;
    localparam int RESET_CYCLES = 4;
    localparam int READY_TIMEOUT = 32;
    localparam int VRAM_TIMEOUT = 16;
    localparam int SPACING_TIMEOUT = 64;

    logic        clk = 1'b0;
    logic        reset;
    logic [15:0] host_address;
    logic [15:0] host_write_data;
    logic        host_write_en;
    logic        host_read_en;
    logic [15:0] host_read_data;
    logic        host_ready;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        active_display;
    logic        line_ended;
    logic        frame_ended;
    logic [13:0] vram_address_even;
    logic [15:0] vram_write_data_even;
    logic        vram_we_even;
    logic [13:0] vram_address_odd;
    logic [15:0] vram_write_data_odd;
    logic        vram_we_odd;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          total_errors;
    logic [31:0] lcg_state = 32'hf20d;

    vdp_top vdp_top_i (
        .clk                  (clk),
        .reset                (reset),
        .host_address         (host_address),
        .host_write_data      (host_write_data),
        .host_write_en        (host_write_en),
        .host_read_en         (host_read_en),
        .host_read_data       (host_read_data),
        .host_ready           (host_ready),
        .r                    (r),
        .g                    (g),
        .b                    (b),
        .vga_hsync            (vga_hsync),
        .vga_vsync            (vga_vsync),
        .active_display       (active_display),
        .line_ended           (line_ended),
        .frame_ended          (frame_ended),
        .vram_address_even    (vram_address_even),
        .vram_write_data_even (vram_write_data_even),
        .vram_we_even         (vram_we_even),
        .vram_address_odd     (vram_address_odd),
        .vram_write_data_odd  (vram_write_data_odd),
        .vram_we_odd          (vram_we_odd)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Upper half of the state has the better random bits
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        error_count++;
    endtask

    task automatic report_test_end(input string name, input int errors_before);
        $display("%s: finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic host_write(input logic [15:0] address, input logic [15:0] data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        host_address <= address;
        host_write_data <= data;
        host_write_en <= 1'b1;
        @(negedge clk);
        while (!host_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!host_ready) begin
            report_timeout("host_ready on a write");
        end
        @(posedge clk);
        host_write_en <= 1'b0;
    endtask

    // Returns the data and the cycle count of the accepting edge
    task automatic host_read(input logic [15:0] address, output logic [15:0] data,
                             output int accept_cycle);
        int cycles;
        cycles = 0;
        @(posedge clk);
        host_address <= address;
        host_read_en <= 1'b1;
        @(negedge clk);
        while (!host_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!host_ready) begin
            report_timeout("host_ready on a read");
        end
        accept_cycle = cycle_count + 1;
        @(posedge clk);
        host_read_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        data = host_read_data;
    endtask

    task automatic wait_vram_write(output logic odd_bank, output logic [13:0] word_address,
                                   output logic [15:0] data);
        int cycles;
        cycles = 0;
        odd_bank = 1'b0;
        word_address = '0;
        data = '0;
        @(negedge clk);
        while (!vram_we_even && !vram_we_odd && cycles < VRAM_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!vram_we_even && !vram_we_odd) begin
            report_timeout("a VRAM bank write");
        end else begin
            odd_bank = vram_we_odd;
            word_address = vram_we_odd ? vram_address_odd : vram_address_even;
            data = vram_we_odd ? vram_write_data_odd : vram_write_data_even;
        end
    endtask

    // Stops at the first sample of a new active region
    task automatic wait_active_start();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (active_display && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        while (!active_display && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!active_display) begin
            report_timeout("active display");
        end
    endtask

    task automatic raster_readback_test();
        int          errors_before;
        int          cycles;
        int          first_accept;
        int          second_accept;
        int          y_accept;
        logic [15:0] first_x;
        logic [15:0] second_x;
        logic [15:0] y;
        errors_before = error_count;
        cycles = 0;
        host_read(16'h0000, first_x, first_accept);
        // Next read is driven one edge later and accepted the edge after
        while (cycle_count < first_accept + 38 && cycles < SPACING_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        host_read(16'h0000, second_x, second_accept);
        compare_value("read accept spacing", second_accept - first_accept, 40);
        compare_value("raster_x delta",
                      (int'(second_x) + vdp_pkg::H_TOTAL - int'(first_x)) % vdp_pkg::H_TOTAL, 40);
        host_read(16'h0002, y, y_accept);
        // Counters leave zero on the first edge after reset is released
        compare_value("raster_y", y,
                      ((y_accept - RESET_CYCLES) / vdp_pkg::H_TOTAL) % vdp_pkg::V_TOTAL);
        report_test_end("raster read-back", errors_before);
    endtask

    task automatic vram_single_write_test();
        int          errors_before;
        logic [15:0] address;
        logic [15:0] data;
        logic        odd_bank;
        logic [13:0] word_address;
        logic [15:0] written;
        errors_before = error_count;
        address = lcg_next() & 16'h7ffe;
        data = lcg_next();
        host_write(16'd6, 16'd0);
        host_write(16'd4, address);
        host_write(16'd5, data);
        wait_vram_write(odd_bank, word_address, written);
        compare_value("vram_we_odd", vram_we_odd, 0);
        compare_value("vram bank", odd_bank, 0);
        compare_value("vram_address_even", word_address, address >> 1);
        compare_value("vram_write_data_even", written, data);
        report_test_end("VRAM single write", errors_before);
    endtask

    task automatic vram_auto_increment_test();
        int          errors_before;
        logic [15:0] address;
        logic [15:0] next_address;
        logic [15:0] first_data;
        logic [15:0] second_data;
        logic        odd_bank;
        logic [13:0] word_address;
        logic [15:0] written;
        errors_before = error_count;
        address = (lcg_next() & 16'h7fff) | 16'h0001;
        next_address = (address + 16'd3) & 16'h7fff;
        first_data = lcg_next();
        second_data = lcg_next();
        host_write(16'd6, 16'd3);
        host_write(16'd4, address);
        host_write(16'd5, first_data);
        wait_vram_write(odd_bank, word_address, written);
        compare_value("first write bank", odd_bank, 1);
        compare_value("first write address", word_address, address >> 1);
        compare_value("first write data", written, first_data);
        host_write(16'd5, second_data);
        wait_vram_write(odd_bank, word_address, written);
        compare_value("second write bank", odd_bank, next_address[0]);
        compare_value("second write address", word_address, next_address >> 1);
        compare_value("second write data", written, second_data);
        report_test_end("VRAM auto-increment", errors_before);
    endtask

    task automatic palette_backdrop_test();
        int          errors_before;
        logic [15:0] colour;
        errors_before = error_count;
        colour = lcg_next();
        host_write(16'd2, 16'd0);
        host_write(16'd3, colour);
        wait_active_start();
        repeat (3) @(negedge clk);
        compare_value("{r, g, b}", {r, g, b}, colour[11:0]);
        report_test_end("palette backdrop", errors_before);
    endtask

    task automatic palette_wrap_test();
        int          errors_before;
        logic [15:0] last_colour;
        logic [15:0] wrapped_colour;
        errors_before = error_count;
        last_colour = lcg_next();
        wrapped_colour = lcg_next();
        host_write(16'd2, 16'd255);
        host_write(16'd3, last_colour);
        host_write(16'd3, wrapped_colour);
        wait_active_start();
        repeat (3) @(negedge clk);
        compare_value("{r, g, b}", {r, g, b}, wrapped_colour[11:0]);
        report_test_end("palette wrap", errors_before);
    endtask

    task automatic ignored_register_test();
        int errors_before;
        int cycles;
        int low_cycles;
        errors_before = error_count;
        host_write(16'd9, lcg_next());
        for (cycles = 0; cycles < VRAM_TIMEOUT; cycles++) begin
            @(negedge clk);
            compare_value("host_ready", host_ready, 1);
            compare_value("vram_we_even", vram_we_even, 0);
            compare_value("vram_we_odd", vram_we_odd, 0);
        end
        // Three samples of blanking flush the colour pipeline
        cycles = 0;
        low_cycles = 0;
        while (low_cycles < 3 && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (active_display) begin
                low_cycles = 0;
            end else begin
                low_cycles++;
            end
        end
        if (low_cycles < 3) begin
            report_timeout("three cycles of blanking");
        end
        compare_value("r", r, 0);
        compare_value("g", g, 0);
        compare_value("b", b, 0);
        report_test_end("ignored registers and blanking", errors_before);
    endtask

    // Walks the first lines of a frame, through the vertical sync lines
    task automatic sync_timing_test();
        int errors_before;
        int cycles;
        int x;
        int y;
        errors_before = error_count;
        cycles = 0;
        @(negedge clk);
        while (!frame_ended && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!frame_ended) begin
            report_timeout("frame_ended");
        end else begin
            compare_value("line_ended", line_ended, 1);
            for (y = 0; y < 13; y++) begin
                for (x = 0; x < vdp_pkg::H_TOTAL; x++) begin
                    @(negedge clk);
                    compare_value("vga_hsync", vga_hsync, !(x >= 16 && x <= 111));
                    compare_value("vga_vsync", vga_vsync, !(y == 11 || y == 12));
                    compare_value("line_ended", line_ended, x == 799);
                    compare_value("frame_ended", frame_ended, 0);
                end
            end
        end
        report_test_end("sync timing", errors_before);
    endtask

    initial begin
        reset = 1'b1;
        host_address = '0;
        host_write_data = '0;
        host_write_en = 1'b0;
        host_read_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        raster_readback_test();
        vram_single_write_test();
        vram_auto_increment_test();
        palette_backdrop_test();
        palette_wrap_test();
        ignored_register_test();
        sync_timing_test();

        total_errors = error_count + vdp_top_i.checker_i.failure_count;
        $display("Summary: 7 tests, %0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, vdp_top_i.checker_i.failure_count);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/vdp_checker.sv
// Bound assertions for the video display processor
// VRAM bank exclusivity, write slot latency, blanking and frame strobes

`timescale 1ns/1ns
`default_nettype none

module vdp_checker (
    input logic                        clk,
    input logic                        reset,
    input logic                        host_ready,
    input logic                        vram_we_even,
    input logic                        vram_we_odd,
    input logic                        active_display,
    input logic [vdp_pkg::COLOR_W-1:0] r,
    input logic [vdp_pkg::COLOR_W-1:0] g,
    input logic [vdp_pkg::COLOR_W-1:0] b,
    input logic                        line_ended,
    input logic                        frame_ended
);

    int failure_count = 0;

    bank_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(vram_we_even && vram_we_odd))
    else begin
        $error("Both VRAM banks written in the same cycle");
        failure_count++;
    end

    // Stall ends with a bank write within one slot period
    write_within_slot: assert property (@(posedge clk) disable iff (reset)
        $fell(host_ready) |-> ##[1:8] (vram_we_even || vram_we_odd))
    else begin
        $error("Pending VRAM write not issued within 8 cycles");
        failure_count++;
    end

    // Colour pipeline is two stages behind active_display
    blanked_rgb: assert property (@(posedge clk) disable iff (reset)
        !$past(active_display, 2) |-> (r == '0 && g == '0 && b == '0))
    else begin
        $error("RGB not blanked outside active display");
        failure_count++;
    end

    frame_on_line_end: assert property (@(posedge clk) disable iff (reset)
        frame_ended |-> line_ended)
    else begin
        $error("frame_ended without line_ended");
        failure_count++;
    end

endmodule

bind vdp_top vdp_checker checker_i (
    .clk            (clk),
    .reset          (reset),
    .host_ready     (host_ready),
    .vram_we_even   (vram_we_even),
    .vram_we_odd    (vram_we_odd),
    .active_display (active_display),
    .r              (r),
    .g              (g),
    .b              (b),
    .line_ended     (line_ended),
    .frame_ended    (frame_ended)
);

`default_nettype wire

//--- design/vdp_top.sv
// Video display processor top level
// Connects raster timing, host register decode, VRAM writer,
// palette and video result stage to the host, VRAM and VGA pins

`timescale 1ns/1ns
`default_nettype none

module vdp_top (
    input  logic                            clk,
    input  logic                            reset,

    // Host port
    input  logic [15:0]                     host_address,
    input  logic [15:0]                     host_write_data,
    input  logic                            host_write_en,
    input  logic                            host_read_en,
    output logic [15:0]                     host_read_data,
    output logic                            host_ready,

    // VGA output
    output logic [vdp_pkg::COLOR_W-1:0]     r,
    output logic [vdp_pkg::COLOR_W-1:0]     g,
    output logic [vdp_pkg::COLOR_W-1:0]     b,
    output logic                            vga_hsync,
    output logic                            vga_vsync,
    output logic                            active_display,
    output logic                            line_ended,
    output logic                            frame_ended,

    // VRAM write ports
    output logic [vdp_pkg::VRAM_ADDR_W-1:0] vram_address_even,
    output logic [15:0]                     vram_write_data_even,
    output logic                            vram_we_even,
    output logic [vdp_pkg::VRAM_ADDR_W-1:0] vram_address_odd,
    output logic [15:0]                     vram_write_data_odd,
    output logic                            vram_we_odd
);

    logic [vdp_pkg::RASTER_X_W-1:0] raster_x;
    logic [vdp_pkg::RASTER_Y_W-1:0] raster_y;

    logic palette_address_we;
    logic palette_data_we;
    logic vram_address_we;
    logic vram_data_we;
    logic vram_increment_we;
    logic read_strobe;
    logic read_y;
    logic vram_write_pending;

    logic [15:0] backdrop_color;

    vdp_raster_timing raster_timing_i (
        .clk            (clk),
        .reset          (reset),
        .raster_x       (raster_x),
        .raster_y       (raster_y),
        .hsync          (vga_hsync),
        .vsync          (vga_vsync),
        .active_display (active_display),
        .line_ended     (line_ended),
        .frame_ended    (frame_ended)
    );

    vdp_register_decode register_decode_i (
        .clk                (clk),
        .reset              (reset),
        .host_address       (host_address),
        .host_write_en      (host_write_en),
        .host_read_en       (host_read_en),
        .vram_write_pending (vram_write_pending),
        .host_ready         (host_ready),
        .palette_address_we (palette_address_we),
        .palette_data_we    (palette_data_we),
        .vram_address_we    (vram_address_we),
        .vram_data_we       (vram_data_we),
        .vram_increment_we  (vram_increment_we),
        .read_strobe        (read_strobe),
        .read_y             (read_y)
    );

    vdp_vram_writer vram_writer_i (
        .clk                  (clk),
        .reset                (reset),
        .write_data           (host_write_data),
        .vram_address_we      (vram_address_we),
        .vram_data_we         (vram_data_we),
        .vram_increment_we    (vram_increment_we),
        .raster_x             (raster_x),
        .vram_write_pending   (vram_write_pending),
        .vram_address_even    (vram_address_even),
        .vram_address_odd     (vram_address_odd),
        .vram_write_data_even (vram_write_data_even),
        .vram_write_data_odd  (vram_write_data_odd),
        .vram_we_even         (vram_we_even),
        .vram_we_odd          (vram_we_odd)
    );

    vdp_palette palette_i (
        .clk                (clk),
        .write_data         (host_write_data),
        .palette_address_we (palette_address_we),
        .palette_data_we    (palette_data_we),
        .backdrop_color     (backdrop_color)
    );

    vdp_video_result video_result_i (
        .clk            (clk),
        .read_strobe    (read_strobe),
        .read_y         (read_y),
        .raster_x       (raster_x),
        .raster_y       (raster_y),
        .active_display (active_display),
        .backdrop_color (backdrop_color),
        .host_read_data (host_read_data),
        .r              (r),
        .g              (g),
        .b              (b)
    );

endmodule

`default_nettype wire

//--- design/vdp_video_result.sv
// Video result stage
// Host read-back of the raster position and blanked RGB output registers

`timescale 1ns/1ns
`default_nettype none

module vdp_video_result (
    input  logic                           clk,

    input  logic                           read_strobe,
    input  logic                           read_y,
    input  logic [vdp_pkg::RASTER_X_W-1:0] raster_x,
    input  logic [vdp_pkg::RASTER_Y_W-1:0] raster_y,

    input  logic                           active_display,
    input  logic [15:0]                    backdrop_color,

    output logic [15:0]                    host_read_data,
    output logic [vdp_pkg::COLOR_W-1:0]    r,
    output logic [vdp_pkg::COLOR_W-1:0]    g,
    output logic [vdp_pkg::COLOR_W-1:0]    b
);

    logic active_display_d;

    // Zero-extended raster position, held until the next read
    always_ff @(posedge clk) begin
        if (read_strobe) begin
            if (read_y) begin
                host_read_data <= {{(16 - vdp_pkg::RASTER_Y_W){1'b0}}, raster_y};
            end else begin
                host_read_data <= {{(16 - vdp_pkg::RASTER_X_W){1'b0}}, raster_x};
            end
        end
    end

    // Delay blanking to line up with the palette read stage
    always_ff @(posedge clk) begin
        active_display_d <= active_display;

        if (active_display_d) begin
            r <= backdrop_color[11:8];
            g <= backdrop_color[7:4];
            b <= backdrop_color[3:0];
        end else begin
            r <= '0;
            g <= '0;
            b <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/vdp_palette.sv
// Palette RAM
// 256 x 16-bit colour entries with an auto-incrementing write address,
// backdrop entry read out every cycle

`timescale 1ns/1ns
`default_nettype none

module vdp_palette (
    input  logic        clk,

    input  logic [15:0] write_data,
    input  logic        palette_address_we,
    input  logic        palette_data_we,

    output logic [15:0] backdrop_color
);

    logic [vdp_pkg::PALETTE_ADDR_W-1:0] write_address;
    logic [15:0]                        palette_ram [0:(1 << vdp_pkg::PALETTE_ADDR_W)-1];

    // Address advances after every data write, wrapping at 256
    always_ff @(posedge clk) begin
        if (palette_address_we) begin
            write_address <= write_data[vdp_pkg::PALETTE_ADDR_W-1:0];
        end else if (palette_data_we) begin
            write_address <= write_address + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (palette_data_we) begin
            palette_ram[write_address] <= write_data;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        backdrop_color <= palette_ram[vdp_pkg::BACKDROP_INDEX];
    end

endmodule

`default_nettype wire

//--- design/vdp_vram_writer.sv
// VRAM host writer
// Holds the VRAM address, increment and data registers and issues
// each pending write to the even or odd bank in the next access slot

`timescale 1ns/1ns
`default_nettype none

module vdp_vram_writer (
    input  logic                            clk,
    input  logic                            reset,

    input  logic [15:0]                     write_data,
    input  logic                            vram_address_we,
    input  logic                            vram_data_we,
    input  logic                            vram_increment_we,

    input  logic [vdp_pkg::RASTER_X_W-1:0]  raster_x,

    output logic                            vram_write_pending,

    output logic [vdp_pkg::VRAM_ADDR_W-1:0] vram_address_even,
    output logic [vdp_pkg::VRAM_ADDR_W-1:0] vram_address_odd,
    output logic [15:0]                     vram_write_data_even,
    output logic [15:0]                     vram_write_data_odd,
    output logic                            vram_we_even,
    output logic                            vram_we_odd
);

    logic [vdp_pkg::VRAM_FULL_ADDR_W-1:0] full_address;
    logic [7:0]                           increment;
    logic [15:0]                          pending_data;
    logic                                 slot;
    logic                                 issue;
    logic                                 odd_bank;

    // One host slot per 8-pixel group
    assign slot = raster_x[2:0] == vdp_pkg::VRAM_SLOT;
    assign issue = vram_write_pending && slot;

    // Low address bit picks the bank
    assign odd_bank = full_address[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            full_address <= '0;
            increment <= '0;
            vram_write_pending <= 1'b0;
            vram_we_even <= 1'b0;
            vram_we_odd <= 1'b0;
        end else begin
            vram_we_even <= issue && !odd_bank;
            vram_we_odd <= issue && odd_bank;

            if (vram_address_we) begin
                full_address <= write_data[vdp_pkg::VRAM_FULL_ADDR_W-1:0];
            end else if (issue) begin
                // Wraps modulo the full address range
                full_address <= full_address + {7'b0, increment};
            end

            if (vram_increment_we) begin
                increment <= write_data[7:0];
            end

            if (vram_data_we) begin
                vram_write_pending <= 1'b1;
            end else if (issue) begin
                vram_write_pending <= 1'b0;
            end
        end
    end

    // Data and word address, qualified by the write enables
    always_ff @(posedge clk) begin
        if (vram_data_we) begin
            pending_data <= write_data;
        end
        if (issue) begin
            vram_address_even <= full_address[vdp_pkg::VRAM_FULL_ADDR_W-1:1];
            vram_address_odd <= full_address[vdp_pkg::VRAM_FULL_ADDR_W-1:1];
            vram_write_data_even <= pending_data;
            vram_write_data_odd <= pending_data;
        end
    end

endmodule

`default_nettype wire

//--- design/vdp_register_decode.sv
// Host register decoder
// Accepts host accesses while ready and turns the register index
// into per-register write strobes and a registered read strobe

`timescale 1ns/1ns
`default_nettype none

module vdp_register_decode (
    input  logic        clk,
    input  logic        reset,

    input  logic [15:0] host_address,
    input  logic        host_write_en,
    input  logic        host_read_en,

    input  logic        vram_write_pending,
    output logic        host_ready,

    output logic        palette_address_we,
    output logic        palette_data_we,
    output logic        vram_address_we,
    output logic        vram_data_we,
    output logic        vram_increment_we,

    output logic        read_strobe,
    output logic        read_y
);

    logic [vdp_pkg::REG_INDEX_W-1:0] reg_index;
    logic                            write_accept;
    logic                            read_accept;

    // Host stalls while a VRAM write waits for its slot
    assign host_ready = !vram_write_pending;

    assign reg_index = host_address[vdp_pkg::REG_INDEX_W-1:0];
    assign write_accept = host_write_en && host_ready;
    assign read_accept = host_read_en && host_ready;

    // Unknown indices fall through with no strobe
    assign palette_address_we = write_accept && reg_index == vdp_pkg::REG_PALETTE_ADDRESS;
    assign palette_data_we = write_accept && reg_index == vdp_pkg::REG_PALETTE_DATA;
    assign vram_address_we = write_accept && reg_index == vdp_pkg::REG_VRAM_ADDRESS;
    assign vram_data_we = write_accept && reg_index == vdp_pkg::REG_VRAM_DATA;
    assign vram_increment_we = write_accept && reg_index == vdp_pkg::REG_VRAM_INCREMENT;

    // Read data is captured one edge after acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            read_strobe <= 1'b0;
        end else begin
            read_strobe <= read_accept;
        end
    end

    always_ff @(posedge clk) begin
        read_y <= host_address[vdp_pkg::READ_SELECT_BIT];
    end

endmodule

`default_nettype wire

//--- design/vdp_raster_timing.sv
// Raster timing generator
// Pixel and line counters for 640x480 with sync, active region
// and end-of-line / end-of-frame strobes

`timescale 1ns/1ns
`default_nettype none

module vdp_raster_timing (
    input  logic                           clk,
    input  logic                           reset,

    output logic [vdp_pkg::RASTER_X_W-1:0] raster_x,
    output logic [vdp_pkg::RASTER_Y_W-1:0] raster_y,

    output logic                           hsync,
    output logic                           vsync,
    output logic                           active_display,

    // Single-cycle strobes
    output logic                           line_ended,
    output logic                           frame_ended
);

    logic x_last;
    logic y_last;
    logic hsync_window;
    logic vsync_window;
    logic x_active;
    logic y_active;

    assign x_last = raster_x == vdp_pkg::H_TOTAL - 1;
    assign y_last = raster_y == vdp_pkg::V_TOTAL - 1;

    // Pixel counter wraps at end of line, line counter follows
    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (x_last) begin
            raster_x <= '0;
            if (y_last) begin
                raster_y <= '0;
            end else begin
                raster_y <= raster_y + 1'b1;
            end
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    // Sync pulses sit between front porch and back porch
    assign hsync_window = raster_x >= vdp_pkg::H_FRONTPORCH &&
                          raster_x < vdp_pkg::H_FRONTPORCH + vdp_pkg::H_SYNC;
    assign vsync_window = raster_y >= vdp_pkg::V_FRONTPORCH &&
                          raster_y < vdp_pkg::V_FRONTPORCH + vdp_pkg::V_SYNC;

    // Negative polarity for both syncs in this mode
    assign hsync = !hsync_window;
    assign vsync = !vsync_window;

    // Active region follows the offscreen span on both axes
    assign x_active = raster_x >= vdp_pkg::H_BLANK;
    assign y_active = raster_y >= vdp_pkg::V_BLANK;
    assign active_display = x_active && y_active;

    assign line_ended = x_last;
    assign frame_ended = x_last && y_last;

endmodule

`default_nettype wire

//--- design/vdp_pkg.sv
// Video display processor shared definitions
// Raster timing for 640x480, host register map and bus widths

`default_nettype none

package vdp_pkg;

    // Horizontal timing in pixels, blanking comes before active video
    localparam int H_ACTIVE = 640;
    localparam int H_FRONTPORCH = 16;
    localparam int H_SYNC = 96;
    localparam int H_BACKPORCH = 48;
    localparam int H_BLANK = H_FRONTPORCH + H_SYNC + H_BACKPORCH;
    localparam int H_TOTAL = H_ACTIVE + H_BLANK;

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONTPORCH = 11;
    localparam int V_SYNC = 2;
    localparam int V_BACKPORCH = 31;
    localparam int V_BLANK = V_FRONTPORCH + V_SYNC + V_BACKPORCH;
    localparam int V_TOTAL = V_ACTIVE + V_BLANK;

    // Bus widths
    localparam int RASTER_X_W = 12;
    localparam int RASTER_Y_W = 11;
    localparam int HOST_DATA_W = 16;
    localparam int REG_INDEX_W = 5;
    localparam int VRAM_ADDR_W = 14;
    localparam int VRAM_FULL_ADDR_W = 15;
    localparam int PALETTE_ADDR_W = 8;
    localparam int COLOR_W = 4;

    // Host register indices, low bits of host_address
    localparam logic [REG_INDEX_W-1:0] REG_PALETTE_ADDRESS = 5'd2;
    localparam logic [REG_INDEX_W-1:0] REG_PALETTE_DATA = 5'd3;
    localparam logic [REG_INDEX_W-1:0] REG_VRAM_ADDRESS = 5'd4;
    localparam logic [REG_INDEX_W-1:0] REG_VRAM_DATA = 5'd5;
    localparam logic [REG_INDEX_W-1:0] REG_VRAM_INCREMENT = 5'd6;

    // Address bit that selects raster y over raster x on reads
    localparam int READ_SELECT_BIT = 1;

    // Host VRAM write slot within each 8-pixel group
    localparam logic [2:0] VRAM_SLOT = 3'd7;

    // Palette entry used as the backdrop
    localparam logic [PALETTE_ADDR_W-1:0] BACKDROP_INDEX = 8'd0;

endpackage

`default_nettype wire
